/* hw/rob_pkg.sv */
/*
  Reorder buffer package
  Fixed configuration and the bundled types shared by the reorder buffer blocks
*/

package rob_pkg;

  // Number of reorder entries, one per outstanding request
  localparam int NUM_ENTRIES = 8;
  // Entry ID width, the minimum that addresses every entry
  localparam int ENTRY_ID_W = $clog2(NUM_ENTRIES);
  // Width of the response payload
  localparam int DATA_W = 16;
  // Cycles from a RAM read strobe to read data valid
  localparam int RAM_RD_LATENCY = 1;
  // Staging FIFO depth covers the read pipeline plus two slots of slack
  localparam int STAGING_DEPTH = RAM_RD_LATENCY + 2;
  // Credit counter must be able to hold the full FIFO depth
  localparam int CREDIT_W = $clog2(STAGING_DEPTH + 1);

  // Unordered response, written into the payload RAM at its entry ID
  typedef struct packed {
    logic [ENTRY_ID_W-1:0] entry_id;
    logic [DATA_W-1:0]     data;
  } resp_push_s;

  // Read request toward the payload RAM
  typedef struct packed {
    logic [ENTRY_ID_W-1:0] addr;
  } ram_rd_s;

endpackage

/* hw/rob_tracker.sv */
/*
  Reorder tracker
  Keeps a free/allocated/returned state per entry and releases the oldest
  entry in allocation order once its response has come back
*/

`timescale 1ns/1ps

module rob_tracker (
  input  logic                           clk,
  input  logic                           rst_n,
  // Allocation port
  input  logic                           alloc_ready,
  output logic                           alloc_valid,
  output logic [rob_pkg::ENTRY_ID_W-1:0] alloc_entry_id,
  // Unordered response strobe
  input  logic                           resp_push_valid,
  input  logic [rob_pkg::ENTRY_ID_W-1:0] resp_push_entry_id,
  // In-order completion toward the read side
  input  logic                           complete_ready,
  output logic                           complete_valid,
  output logic [rob_pkg::ENTRY_ID_W-1:0] complete_entry_id
);

  import rob_pkg::*;

  // Per-entry life cycle, the last code is never used
  typedef enum logic [1:0] {
    ENTRY_FREE     = 2'b00,
    ENTRY_ALLOC    = 2'b01,
    ENTRY_RETURNED = 2'b10
  } entry_state_e;

  entry_state_e          state [NUM_ENTRIES];
  logic [ENTRY_ID_W-1:0] alloc_ptr;
  logic [ENTRY_ID_W-1:0] oldest_ptr;
  logic                  alloc_fire;
  logic                  complete_fire;

  // IDs are handed out in rotating order, so the next one is free only
  // when the entry it points at has been fully drained
  assign alloc_valid    = (state[alloc_ptr] == ENTRY_FREE);
  assign alloc_entry_id = alloc_ptr;
  assign alloc_fire     = alloc_valid && alloc_ready;

  // The oldest entry completes only after its response is in the RAM
  assign complete_valid    = (state[oldest_ptr] == ENTRY_RETURNED);
  assign complete_entry_id = oldest_ptr;
  assign complete_fire     = complete_valid && complete_ready;

  // Both pointers wrap at NUM_ENTRIES
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alloc_ptr  <= '0;
      oldest_ptr <= '0;
    end else begin
      if (alloc_fire) begin
        alloc_ptr <= (alloc_ptr == ENTRY_ID_W'(NUM_ENTRIES - 1)) ? '0 : alloc_ptr + 1'b1;
      end
      if (complete_fire) begin
        oldest_ptr <= (oldest_ptr == ENTRY_ID_W'(NUM_ENTRIES - 1)) ? '0 : oldest_ptr + 1'b1;
      end
    end
  end

  // The three updates always hit different entries: allocation takes a free
  // one, a push hits an allocated one and a completion a returned one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        state[i] <= ENTRY_FREE;
      end
    end else begin
      if (alloc_fire) begin
        state[alloc_ptr] <= ENTRY_ALLOC;
      end
      if (resp_push_valid) begin
        state[resp_push_entry_id] <= ENTRY_RETURNED;
      end
      if (complete_fire) begin
        state[oldest_ptr] <= ENTRY_FREE;
      end
    end
  end

endmodule

/* hw/rob_read_credit.sv */
/*
  Read credit counter
  Turns in-order completions into RAM reads while the staging FIFO has room
*/

`timescale 1ns/1ps

module rob_read_credit (
  input  logic                           clk,
  input  logic                           rst_n,
  // Completion from the tracker
  input  logic                           complete_valid,
  input  logic [rob_pkg::ENTRY_ID_W-1:0] complete_entry_id,
  output logic                           complete_ready,
  // Read request toward the RAM
  output logic                           rd_valid,
  output rob_pkg::ram_rd_s               rd_req,
  // One credit per item popped from the staging FIFO
  input  logic                           credit_return
);

  import rob_pkg::*;

  logic [CREDIT_W-1:0] credit_count;

  // A completion is accepted only when a FIFO slot is reserved for its data
  assign complete_ready = (credit_count != '0);
  assign rd_valid       = complete_valid && complete_ready;
  assign rd_req.addr    = complete_entry_id;

  // Starts full, since the FIFO is empty out of reset
  // A read and a returned credit in the same cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_count <= CREDIT_W'(STAGING_DEPTH);
    end else begin
      case ({rd_valid, credit_return})
        2'b10:   credit_count <= credit_count - 1'b1;
        2'b01:   credit_count <= credit_count + 1'b1;
        default: credit_count <= credit_count;
      endcase
    end
  end

endmodule

/* hw/rob_ram.sv */
/*
  Payload RAM
  1R1W array indexed by entry ID with a fixed read latency and a data valid strobe
*/

`timescale 1ns/1ps

module rob_ram (
  input  logic                       clk,
  input  logic                       rst_n,
  // Write port, fed straight from the unordered responses
  input  logic                       wr_valid,
  input  rob_pkg::resp_push_s        wr,
  // Read port
  input  logic                       rd_valid,
  input  rob_pkg::ram_rd_s           rd_req,
  output logic                       rd_data_valid,
  output logic [rob_pkg::DATA_W-1:0] rd_data
);

  import rob_pkg::*;

  logic [DATA_W-1:0]         mem [NUM_ENTRIES];
  logic [DATA_W-1:0]         data_q [RAM_RD_LATENCY];
  logic [RAM_RD_LATENCY-1:0] vld_q;

  // A write always lands before any read of the same entry, because the
  // tracker only completes an entry after its push
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr.entry_id] <= wr.data;
    end
  end

  // Registered read followed by any extra latency stages
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      data_q[0] <= mem[rd_req.addr];
    end
    for (int s = 1; s < RAM_RD_LATENCY; s++) begin
      data_q[s] <= data_q[s-1];
    end
  end

  // Valid strobe tracks the data through the same number of stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= rd_valid;
      for (int s = 1; s < RAM_RD_LATENCY; s++) begin
        vld_q[s] <= vld_q[s-1];
      end
    end
  end

  assign rd_data_valid = vld_q[RAM_RD_LATENCY-1];
  assign rd_data       = data_q[RAM_RD_LATENCY-1];

endmodule

/* hw/rob_staging_fifo.sv */
/*
  Staging FIFO
  Flop ring behind the RAM that holds read data against pop back-pressure
  and hands a credit back for every pop
*/

`timescale 1ns/1ps

module rob_staging_fifo (
  input  logic                       clk,
  input  logic                       rst_n,
  // Push side, driven by RAM read data
  input  logic                       push_valid,
  input  logic [rob_pkg::DATA_W-1:0] push_data,
  // Pop side, the reordered output
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output logic [rob_pkg::DATA_W-1:0] pop_data,
  // Pulses once per pop transfer
  output logic                       credit_return
);

  import rob_pkg::*;

  logic [DATA_W-1:0]                    ring [STAGING_DEPTH];
  logic [$clog2(STAGING_DEPTH)-1:0]     wr_ptr;
  logic [$clog2(STAGING_DEPTH)-1:0]     rd_ptr;
  logic [CREDIT_W-1:0]                  items;
  logic                                 pop_fire;

  // Head of the ring is shown directly, so data holds while stalled
  assign pop_valid     = (items != '0);
  assign pop_data      = ring[rd_ptr];
  assign pop_fire      = pop_valid && pop_ready;
  assign credit_return = pop_fire;

  // No full check is needed, the credit counter bounds the pushes
  always_ff @(posedge clk) begin
    if (push_valid) begin
      ring[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      items  <= '0;
    end else begin
      if (push_valid) begin
        wr_ptr <= (wr_ptr == ($bits(wr_ptr))'(STAGING_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == ($bits(rd_ptr))'(STAGING_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      case ({push_valid, pop_fire})
        2'b10:   items <= items + 1'b1;
        2'b01:   items <= items - 1'b1;
        default: items <= items;
      endcase
    end
  end

endmodule

/* hw/rob_top.sv */
/*
  Reorder buffer top level
  Allocates entry IDs, stores out-of-order responses and pops them in allocation order
*/

`timescale 1ns/1ps

module rob_top (
  input  logic                           clk,
  input  logic                           rst_n,
  // Allocation port
  input  logic                           alloc_ready,
  output logic                           alloc_valid,
  output logic [rob_pkg::ENTRY_ID_W-1:0] alloc_entry_id,
  // Unordered response push, a strobe with no ready
  input  logic                           resp_push_valid,
  input  rob_pkg::resp_push_s            resp_push,
  // Reordered pop
  input  logic                           pop_ready,
  output logic                           pop_valid,
  output logic [rob_pkg::DATA_W-1:0]     pop_data
);

  import rob_pkg::*;

  // Tracker to credit counter
  logic                  complete_valid;
  logic                  complete_ready;
  logic [ENTRY_ID_W-1:0] complete_entry_id;
  // Credit counter to RAM
  logic                  rd_valid;
  ram_rd_s               rd_req;
  // RAM to FIFO
  logic                  rd_data_valid;
  logic [DATA_W-1:0]     rd_data;
  // FIFO back to credit counter
  logic                  credit_return;

  // Orders the completions and hands out IDs
  rob_tracker tracker_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .alloc_ready        (alloc_ready),
    .alloc_valid        (alloc_valid),
    .alloc_entry_id     (alloc_entry_id),
    .resp_push_valid    (resp_push_valid),
    .resp_push_entry_id (resp_push.entry_id),
    .complete_ready     (complete_ready),
    .complete_valid     (complete_valid),
    .complete_entry_id  (complete_entry_id)
  );

  // Gates reads on free FIFO slots
  rob_read_credit read_credit_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .complete_valid    (complete_valid),
    .complete_entry_id (complete_entry_id),
    .complete_ready    (complete_ready),
    .rd_valid          (rd_valid),
    .rd_req            (rd_req),
    .credit_return     (credit_return)
  );

  // Responses are written at their own entry ID
  rob_ram ram_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid      (resp_push_valid),
    .wr            (resp_push),
    .rd_valid      (rd_valid),
    .rd_req        (rd_req),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  rob_staging_fifo staging_fifo_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_valid    (rd_data_valid),
    .push_data     (rd_data),
    .pop_ready     (pop_ready),
    .pop_valid     (pop_valid),
    .pop_data      (pop_data),
    .credit_return (credit_return)
  );

endmodule

/* testbench/rob_properties.sv */
/*
  Reorder buffer properties
  Checks pop stability, the state after reset and allocation availability
*/

`timescale 1ns/1ps

module rob_properties (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       alloc_valid,
  input logic                       alloc_ready,
  input logic                       pop_valid,
  input logic                       pop_ready,
  input logic [rob_pkg::DATA_W-1:0] pop_data
);

  import rob_pkg::*;

  // Entries allocated and not yet popped, counted at the ports
  int outstanding;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(alloc_valid && alloc_ready)
                     - int'(pop_valid && pop_ready);
    end
  end

  // A stalled pop holds its data
  pop_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (pop_valid && !pop_ready) |=> $stable(pop_data))
    else $error("pop_data changed while pop was stalled");

  // Nothing can be queued for pop right out of reset
  pop_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !pop_valid)
    else $error("pop_valid high in the first cycle after reset");

  // With a free slot somewhere the next rotating ID must be free too
  alloc_available: assert property (@(posedge clk) disable iff (!rst_n)
    (outstanding < NUM_ENTRIES) |-> alloc_valid)
    else $error("alloc_valid low with fewer than NUM_ENTRIES outstanding");

endmodule

bind rob_top rob_properties props_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .alloc_valid (alloc_valid),
  .alloc_ready (alloc_ready),
  .pop_valid   (pop_valid),
  .pop_ready   (pop_ready),
  .pop_data    (pop_data)
);

/* testbench/tb_rob_top.sv */
/*
  Reorder buffer testbench
  Allocates entries, returns responses out of order and checks that payloads
  pop in allocation order against a reference model
*/

`timescale 1ns/1ps

module tb_rob_top;

  import rob_pkg::*;

  // About 260 transactions at 40 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 260 * 40 + 1600;

  logic                  clk;
  logic                  rst_n;
  logic                  alloc_ready;
  logic                  alloc_valid;
  logic [ENTRY_ID_W-1:0] alloc_entry_id;
  logic                  resp_push_valid;
  resp_push_s            resp_push;
  logic                  pop_ready;
  logic                  pop_valid;
  logic [DATA_W-1:0]     pop_data;

  // Sequence numbers in allocation order, oldest at the front
  int unsigned order_q[$];
  // Sequence number held by each entry
  int unsigned entry_seq [NUM_ENTRIES];
  int unsigned alloc_total;
  int unsigned pop_total;
  int unsigned cycle_count;

  rob_top dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .alloc_ready     (alloc_ready),
    .alloc_valid     (alloc_valid),
    .alloc_entry_id  (alloc_entry_id),
    .resp_push_valid (resp_push_valid),
    .resp_push       (resp_push),
    .pop_ready       (pop_ready),
    .pop_valid       (pop_valid),
    .pop_data        (pop_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Payload model, a scrambled copy of the allocation sequence number
  function automatic logic [DATA_W-1:0] expected_data(input int unsigned seq);
    logic [31:0] mix;
    mix = seq * 32'h9e37_79b1;
    return mix[31:16] ^ seq[15:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // Called at a falling edge with alloc_valid high, so the transfer is certain
  // IDs must rotate from zero in allocation order
  task automatic take_alloc(output logic [ENTRY_ID_W-1:0] id);
    id = alloc_entry_id;
    check_value("alloc_entry_id", 32'(id), alloc_total % NUM_ENTRIES);
    entry_seq[id] = alloc_total;
    order_q.push_back(alloc_total);
    alloc_total++;
    alloc_ready = 1'b1;
  endtask

  task automatic alloc_one(output logic [ENTRY_ID_W-1:0] id);
    @(negedge clk);
    while (!alloc_valid) @(negedge clk);
    take_alloc(id);
    @(negedge clk);
    alloc_ready = 1'b0;
  endtask

  task automatic push_resp(input logic [ENTRY_ID_W-1:0] id);
    @(negedge clk);
    resp_push_valid    = 1'b1;
    resp_push.entry_id = id;
    resp_push.data     = expected_data(entry_seq[id]);
    @(negedge clk);
    resp_push_valid = 1'b0;
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (order_q.size() != 0) @(negedge clk);
  endtask

  // Random allocations, returns and pop stalls until n items have popped
  task automatic run_random(input int unsigned n);
    logic [ENTRY_ID_W-1:0] pending[$];
    logic [ENTRY_ID_W-1:0] id;
    int unsigned           issued;
    int                    idx;
    issued = 0;
    while (issued < n || pending.size() != 0 || order_q.size() != 0) begin
      @(negedge clk);
      alloc_ready     = 1'b0;
      resp_push_valid = 1'b0;
      pop_ready       = ($urandom % 4) != 0;
      // Returns come first so an ID allocated this cycle is never picked
      if (pending.size() != 0 && ($urandom % 2) != 0) begin
        idx = int'($urandom % pending.size());
        id  = pending[idx];
        pending.delete(idx);
        resp_push_valid    = 1'b1;
        resp_push.entry_id = id;
        resp_push.data     = expected_data(entry_seq[id]);
      end
      if (issued < n && alloc_valid && ($urandom % 2) != 0) begin
        take_alloc(id);
        pending.push_back(id);
        issued++;
      end
    end
    @(negedge clk);
    alloc_ready     = 1'b0;
    resp_push_valid = 1'b0;
    pop_ready       = 1'b1;
  endtask

  // Every pop must carry the payload of the oldest allocation
  always @(posedge clk) begin
    int unsigned seq;
    if (rst_n && pop_valid && pop_ready) begin
      if (order_q.size() == 0) begin
        $display("pop transfer seen with no allocation outstanding");
        $display("TB FAILED");
        $fatal(1);
      end else begin
        seq = order_q.pop_front();
        check_value("pop_data", 32'(pop_data), 32'(expected_data(seq)));
        pop_total++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the reorder buffer stopped making progress",
               cycle_count);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  initial begin
    logic [ENTRY_ID_W-1:0] ids [NUM_ENTRIES];
    logic [ENTRY_ID_W-1:0] extra_ids[$];
    logic [ENTRY_ID_W-1:0] id;
    int unsigned           pops_before;
    void'($urandom(32'h3bb));
    rst_n           = 1'b0;
    alloc_ready     = 1'b0;
    resp_push_valid = 1'b0;
    resp_push       = '0;
    pop_ready       = 1'b0;
    alloc_total     = 0;
    pop_total       = 0;
    cycle_count     = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("alloc_valid", 32'(alloc_valid), 32'd1);
    check_value("pop_valid", 32'(pop_valid), 32'd0);

    // Fill all eight entries, then a ninth request must wait
    for (int i = 0; i < NUM_ENTRIES; i++) alloc_one(ids[i]);
    @(negedge clk);
    alloc_ready = 1'b1;
    repeat (4) begin
      check_value("alloc_valid", 32'(alloc_valid), 32'd0);
      @(negedge clk);
    end
    alloc_ready = 1'b0;
    pop_ready   = 1'b1;
    pops_before = pop_total;
    push_resp(ids[0]);
    while (pop_total == pops_before) @(negedge clk);
    alloc_one(id);
    // Returns in allocation order pop straight through
    for (int i = 1; i < NUM_ENTRIES; i++) push_resp(ids[i]);
    push_resp(id);
    wait_drain();

    // Reverse returns hold everything back until the oldest arrives
    for (int i = 0; i < NUM_ENTRIES; i++) alloc_one(ids[i]);
    pops_before = pop_total;
    for (int i = NUM_ENTRIES - 1; i > 0; i--) push_resp(ids[i]);
    repeat (5) begin
      @(negedge clk);
      check_value("pop_valid", 32'(pop_valid), 32'd0);
    end
    check_value("pop_total", pop_total, pops_before);
    push_resp(ids[0]);
    wait_drain();

    run_random(200);

    // Stalled pop: only the FIFO depth worth of entries can be freed
    pop_ready = 1'b0;
    for (int i = 0; i < NUM_ENTRIES; i++) alloc_one(ids[i]);
    for (int i = 0; i < NUM_ENTRIES; i++) push_resp(ids[(i * 3) % NUM_ENTRIES]);
    pops_before = pop_total;
    repeat (50) begin
      @(negedge clk);
      alloc_ready = 1'b0;
      if (alloc_valid) begin
        take_alloc(id);
        extra_ids.push_back(id);
      end
      // The head item must stay offered for the whole stall
      check_value("pop_valid", 32'(pop_valid), 32'd1);
    end
    @(negedge clk);
    alloc_ready = 1'b0;
    check_value("alloc_valid", 32'(alloc_valid), 32'd0);
    check_value("pop_valid", 32'(pop_valid), 32'd1);
    check_value("extra allocations", 32'(extra_ids.size()), 32'(STAGING_DEPTH));
    pop_ready = 1'b1;
    foreach (extra_ids[i]) push_resp(extra_ids[i]);
    wait_drain();
    alloc_one(id);
    push_resp(id);
    wait_drain();

    // No item may remain once every allocation has popped
    check_value("pop_valid", 32'(pop_valid), 32'd0);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* project.f */
hw/rob_pkg.sv
hw/rob_tracker.sv
hw/rob_read_credit.sv
hw/rob_ram.sv
hw/rob_staging_fifo.sv
hw/rob_top.sv
testbench/rob_properties.sv
testbench/tb_rob_top.sv

/* Makefile */
SIM       ?= verilator
SIMFLAGS  ?= --binary --timing --assert -j 0
TOP       ?= tb_rob_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^TB PASSED$$' $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
